// ==== Makefile ====
# Verilator lint and simulation of the flow-table controller

VERILATOR ?= verilator
FILELIST  ?= flow_table.f
TB_TOP    ?= tb_flow_table_ctrl
RTL_TOP   ?= flow_table_ctrl
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing -Wall

BIN := $(BUILD_DIR)/V$(TB_TOP)

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

$(BIN):
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(BUILD_DIR) -o V$(TB_TOP)

sim: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then exit 1; fi
	@grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== flow_table.f ====
+incdir+hdl
+incdir+tb
hdl/flow_table_pkg.sv
hdl/flow_pipe_pkg.sv
hdl/flow_port_arbiter.sv
hdl/flow_table_lookup.sv
hdl/flow_action_stats.sv
hdl/flow_table_ctrl.sv
tb/tb_flow_table_ctrl.sv

// ==== hdl/flow_action_stats.sv ====
// action choice, per-entry statistics, hit/miss and drop counters,
// lookup done pulses and host responses

`timescale 1ns/1ps
`include "flow_consts.svh"

module flow_action_stats (
   input  logic                            asclk,
   input  logic                            aresetn,
   input  flow_pipe_pkg::execute_stage_t   exec_in,
   output logic [`FLOW_N_PORTS-1:0]        lookup_done,
   output flow_table_pkg::action_t         action_out,
   output logic                            host_done,
   output flow_pipe_pkg::host_rsp_t        host_rsp,
   output flow_table_pkg::flow_counters_t  counters,
   output flow_table_pkg::cnt_t            drop_count [`FLOW_N_PORTS]
);

   localparam int EX_DEPTH = 1 << `FLOW_EX_IDX_W;

   flow_table_pkg::flow_stats_t ex_stats [EX_DEPTH];
   flow_table_pkg::flow_stats_t wc_stats [`FLOW_WC_DEPTH];
   flow_table_pkg::wc_idx_t     host_wc_idx;
   flow_pipe_pkg::port_idx_t    port;
   logic                        is_lookup;
   logic                        is_host;
   logic                        host_wr;

   assign is_lookup   = exec_in.valid && !exec_in.host_acc;
   assign is_host     = exec_in.valid && exec_in.host_acc;
   assign host_wr     = is_host && (exec_in.host_op == flow_pipe_pkg::HOST_WRITE);
   assign host_wc_idx = exec_in.host_idx[`FLOW_WC_IDX_W-1:0];
   assign port        = flow_pipe_pkg::port_idx_t'(exec_in.req_id);

   function automatic flow_table_pkg::flow_stats_t stats_add(
      input flow_table_pkg::flow_stats_t cur,
      input flow_table_pkg::pkt_len_t    len
   );
      flow_table_pkg::flow_stats_t nxt;
      nxt.pkt_count  = cur.pkt_count + 1'b1;
      nxt.byte_count = cur.byte_count + flow_table_pkg::cnt_t'(len);
      return nxt;
   endfunction

   // --------------------
   // exact first, then wildcard, else drop
   always_ff @(posedge asclk) begin
      if (exec_in.ex_hit) begin
         action_out <= exec_in.ex_action;
      end else if (exec_in.wc_hit) begin
         action_out <= exec_in.wc_action;
      end else begin
         action_out <= '0;
      end
   end

   always_ff @(posedge asclk) begin
      if (!aresetn) begin
         lookup_done <= '0;
         host_done   <= 1'b0;
      end else begin
         lookup_done <= '0;
         if (is_lookup) begin
            lookup_done[port] <= 1'b1;
         end
         host_done <= is_host;
      end
   end

   // --------------------
   // per-entry statistics, read and written back in one cycle
   always_ff @(posedge asclk) begin
      if (!aresetn) begin
         for (int i = 0; i < EX_DEPTH; i++) begin
            ex_stats[i] <= '0;
         end
         for (int i = 0; i < `FLOW_WC_DEPTH; i++) begin
            wc_stats[i] <= '0;
         end
      end else if (host_wr) begin
         if (exec_in.tbl_sel) begin
            wc_stats[host_wc_idx] <= '0;
         end else begin
            ex_stats[exec_in.host_idx] <= '0;
         end
      end else if (is_lookup && exec_in.ex_hit) begin
         ex_stats[exec_in.ex_idx] <= stats_add(ex_stats[exec_in.ex_idx], exec_in.pkt_len);
      end else if (is_lookup && exec_in.wc_hit) begin
         wc_stats[exec_in.wc_idx] <= stats_add(wc_stats[exec_in.wc_idx], exec_in.pkt_len);
      end
   end

   // global counters
   always_ff @(posedge asclk) begin
      if (!aresetn) begin
         counters <= '0;
         for (int p = 0; p < `FLOW_N_PORTS; p++) begin
            drop_count[p] <= '0;
         end
      end else if (is_lookup) begin
         if (exec_in.ex_hit) begin
            counters.exact_hit <= counters.exact_hit + 1'b1;
         end else begin
            counters.exact_miss <= counters.exact_miss + 1'b1;
         end
         if (exec_in.wc_hit) begin
            counters.wc_hit <= counters.wc_hit + 1'b1;
         end else begin
            counters.wc_miss <= counters.wc_miss + 1'b1;
         end
         if (!exec_in.ex_hit && !exec_in.wc_hit) begin
            drop_count[port] <= drop_count[port] + 1'b1;
         end
      end
   end

   // --------------------
   // host response, a write reports cleared stats
   always_ff @(posedge asclk) begin
      if (is_host) begin
         host_rsp.match  <= exec_in.rd_match;
         host_rsp.mask   <= exec_in.rd_mask;
         host_rsp.action <= exec_in.rd_action;
         if (exec_in.host_op == flow_pipe_pkg::HOST_WRITE) begin
            host_rsp.stats <= '0;
         end else if (exec_in.tbl_sel) begin
            host_rsp.stats <= wc_stats[host_wc_idx];
         end else begin
            host_rsp.stats <= ex_stats[exec_in.host_idx];
         end
      end
   end

endmodule

// ==== hdl/flow_consts.svh ====
// widths, table depths, port count and pipeline latency
// of the flow-table controller

`ifndef FLOW_CONSTS_SVH
`define FLOW_CONSTS_SVH

// key and action words
`define FLOW_MATCH_W    64
`define FLOW_ACTION_W   32
`define FLOW_PKT_LEN_W  16

// exact table has 2**FLOW_EX_IDX_W entries
`define FLOW_EX_IDX_W   4
`define FLOW_WC_DEPTH   8
`define FLOW_WC_IDX_W   3

// lookup requesters, the host comes on top of these
`define FLOW_N_PORTS    4

`define FLOW_CNT_W      32

// cycles from ack to done
`define FLOW_LATENCY    3

`endif

// ==== hdl/flow_pipe_pkg.sv ====
// types for requests, the decode and execute pipeline stages
// and host responses

`include "flow_consts.svh"

package flow_pipe_pkg;

   // ports 0..N-1 look up, N is the host
   typedef logic [$clog2(`FLOW_N_PORTS+1)-1:0] req_id_t;
   typedef logic [$clog2(`FLOW_N_PORTS)-1:0]   port_idx_t;

   localparam req_id_t HOST_REQ_ID = req_id_t'(`FLOW_N_PORTS);

   typedef struct packed {
      flow_table_pkg::match_t   match;
      flow_table_pkg::pkt_len_t pkt_len;
   } lookup_req_t;

   typedef enum logic {
      HOST_READ  = 1'b0,
      HOST_WRITE = 1'b1
   } host_op_t;

   // tbl_sel 0 is exact, 1 is wildcard; mask bit 1 means must equal
   typedef struct packed {
      host_op_t                op;
      logic                    tbl_sel;
      flow_table_pkg::ex_idx_t index;
      flow_table_pkg::match_t  match;
      flow_table_pkg::match_t  mask;
      flow_table_pkg::action_t action;
   } host_req_t;

   typedef struct packed {
      logic        valid;
      req_id_t     req_id;
      lookup_req_t lookup;
      host_req_t   host;
   } decode_stage_t;

   typedef struct packed {
      logic                     valid;
      req_id_t                  req_id;
      flow_table_pkg::pkt_len_t pkt_len;
      logic                     ex_hit;
      flow_table_pkg::ex_idx_t  ex_idx;
      logic                     wc_hit;
      flow_table_pkg::wc_idx_t  wc_idx;
      flow_table_pkg::action_t  ex_action;
      flow_table_pkg::action_t  wc_action;
      // host access fields
      logic                     host_acc;
      host_op_t                 host_op;
      logic                     tbl_sel;
      flow_table_pkg::ex_idx_t  host_idx;
      flow_table_pkg::match_t   rd_match;
      flow_table_pkg::match_t   rd_mask;
      flow_table_pkg::action_t  rd_action;
   } execute_stage_t;

   typedef struct packed {
      flow_table_pkg::match_t      match;
      flow_table_pkg::match_t      mask;
      flow_table_pkg::action_t     action;
      flow_table_pkg::flow_stats_t stats;
   } host_rsp_t;

endpackage

// ==== hdl/flow_port_arbiter.sv ====
// round-robin arbiter over the lookup ports and the host,
// ack pulse and capture of the granted request

`timescale 1ns/1ps
`include "flow_consts.svh"

module flow_port_arbiter (
   input  logic                         asclk,
   input  logic                         aresetn,
   input  logic [`FLOW_N_PORTS-1:0]     lookup_valid,
   input  flow_pipe_pkg::lookup_req_t   lookup_req [`FLOW_N_PORTS],
   input  logic                         host_valid,
   input  flow_pipe_pkg::host_req_t     host_req,
   output logic [`FLOW_N_PORTS-1:0]     lookup_ack,
   output logic                         host_ack,
   output flow_pipe_pkg::decode_stage_t decode_out
);

   localparam int N_REQ = `FLOW_N_PORTS + 1;

   flow_pipe_pkg::req_id_t       rr_ptr;
   flow_pipe_pkg::req_id_t       gnt_id;
   flow_pipe_pkg::req_id_t       gnt_q;
   logic [N_REQ-1:0]             req_vec;
   logic [N_REQ-1:0]             grant;
   logic [N_REQ-1:0]             ack_q;
   flow_pipe_pkg::decode_stage_t decode_next;

   // host is the top requester
   assign req_vec    = {host_valid, lookup_valid};
   assign lookup_ack = ack_q[`FLOW_N_PORTS-1:0];
   assign host_ack   = ack_q[`FLOW_N_PORTS];

   // --------------------
   // rotating pointer, steps every cycle
   always_ff @(posedge asclk) begin
      if (!aresetn) begin
         rr_ptr <= '0;
      end else if (rr_ptr == flow_pipe_pkg::HOST_REQ_ID) begin
         rr_ptr <= '0;
      end else begin
         rr_ptr <= rr_ptr + 1'b1;
      end
   end

   // walk back from the far end so the first requester after the pointer wins
   // a requester acked in this cycle is still holding, skip it
   always_comb begin
      int pos;
      grant  = '0;
      gnt_id = '0;
      for (int k = N_REQ - 1; k >= 0; k--) begin
         pos = int'(rr_ptr) + k;
         if (pos >= N_REQ) begin
            pos = pos - N_REQ;
         end
         if (req_vec[pos] && !ack_q[pos]) begin
            grant      = '0;
            grant[pos] = 1'b1;
            gnt_id     = flow_pipe_pkg::req_id_t'(pos);
         end
      end
   end

   always_ff @(posedge asclk) begin
      if (!aresetn) begin
         ack_q <= '0;
      end else begin
         ack_q <= grant;
      end
   end

   always_ff @(posedge asclk) begin
      gnt_q <= gnt_id;
   end

   // --------------------
   // requester still holds its request in the ack cycle
   always_comb begin
      decode_next.valid  = |ack_q;
      decode_next.req_id = gnt_q;
      decode_next.host   = host_req;
      if (gnt_q == flow_pipe_pkg::HOST_REQ_ID) begin
         decode_next.lookup = '0;
      end else begin
         decode_next.lookup = lookup_req[flow_pipe_pkg::port_idx_t'(gnt_q)];
      end
   end

   always_ff @(posedge asclk) begin
      if (!aresetn) begin
         decode_out.valid <= 1'b0;
      end else begin
         decode_out <= decode_next;
      end
   end

endmodule

// ==== hdl/flow_table_ctrl.sv ====
// flow-table controller top level
// arbiter, table lookup and action/statistics stages

`timescale 1ns/1ps
`include "flow_consts.svh"

module flow_table_ctrl (
   input  logic                           asclk,
   input  logic                           aresetn,
   // lookup ports
   input  logic [`FLOW_N_PORTS-1:0]       lookup_valid,
   input  flow_pipe_pkg::lookup_req_t     lookup_req [`FLOW_N_PORTS],
   output logic [`FLOW_N_PORTS-1:0]       lookup_ack,
   output logic [`FLOW_N_PORTS-1:0]       lookup_done,
   output flow_table_pkg::action_t        action_out,
   // host access
   input  logic                           host_valid,
   input  flow_pipe_pkg::host_req_t       host_req,
   output logic                           host_ack,
   output logic                           host_done,
   output flow_pipe_pkg::host_rsp_t       host_rsp,
   // counters
   output flow_table_pkg::flow_counters_t counters,
   output flow_table_pkg::cnt_t           drop_count [`FLOW_N_PORTS]
);

   flow_pipe_pkg::decode_stage_t  decode;
   flow_pipe_pkg::execute_stage_t exec;

   flow_port_arbiter u_arbiter (
      .asclk        (asclk),
      .aresetn      (aresetn),
      .lookup_valid (lookup_valid),
      .lookup_req   (lookup_req),
      .host_valid   (host_valid),
      .host_req     (host_req),
      .lookup_ack   (lookup_ack),
      .host_ack     (host_ack),
      .decode_out   (decode)
   );

   flow_table_lookup u_lookup (
      .asclk     (asclk),
      .aresetn   (aresetn),
      .decode_in (decode),
      .exec_out  (exec)
   );

   flow_action_stats u_result (
      .asclk       (asclk),
      .aresetn     (aresetn),
      .exec_in     (exec),
      .lookup_done (lookup_done),
      .action_out  (action_out),
      .host_done   (host_done),
      .host_rsp    (host_rsp),
      .counters    (counters),
      .drop_count  (drop_count)
   );

endmodule

// ==== hdl/flow_table_lookup.sv ====
// exact and wildcard flow tables, two-way hash of the key,
// parallel wildcard compare, host table writes and reads

`timescale 1ns/1ps
`include "flow_consts.svh"

module flow_table_lookup (
   input  logic                          asclk,
   input  logic                          aresetn,
   input  flow_pipe_pkg::decode_stage_t  decode_in,
   output flow_pipe_pkg::execute_stage_t exec_out
);

   localparam int EX_DEPTH = 1 << `FLOW_EX_IDX_W;
   localparam int CHUNKS   = `FLOW_MATCH_W / `FLOW_EX_IDX_W;

   // exact table
   flow_table_pkg::match_t        ex_match  [EX_DEPTH];
   flow_table_pkg::action_t       ex_action [EX_DEPTH];
   logic [EX_DEPTH-1:0]           ex_valid;
   // wildcard table
   flow_table_pkg::match_t        wc_value  [`FLOW_WC_DEPTH];
   flow_table_pkg::match_t        wc_mask   [`FLOW_WC_DEPTH];
   flow_table_pkg::action_t       wc_action [`FLOW_WC_DEPTH];
   logic [`FLOW_WC_DEPTH-1:0]     wc_valid;

   flow_table_pkg::match_t        key;
   flow_table_pkg::ex_idx_t       h_xor;
   flow_table_pkg::ex_idx_t       h_sum;
   flow_table_pkg::ex_idx_t       hi;
   flow_table_pkg::wc_idx_t       hw;
   flow_table_pkg::wc_idx_t       wc_idx;
   logic                          slot0_hit;
   logic                          slot1_hit;
   logic                          wc_hit;
   logic                          is_host;
   logic                          host_wr;
   flow_pipe_pkg::execute_stage_t exec_next;

   assign key     = decode_in.lookup.match;
   assign is_host = decode_in.valid && (decode_in.req_id == flow_pipe_pkg::HOST_REQ_ID);
   assign host_wr = is_host && (decode_in.host.op == flow_pipe_pkg::HOST_WRITE);
   assign hi      = decode_in.host.index;
   assign hw      = decode_in.host.index[`FLOW_WC_IDX_W-1:0];

   // --------------------
   // hash 0 xors the key nibbles, hash 1 adds them mod table size
   always_comb begin
      h_xor = '0;
      h_sum = '0;
      for (int n = 0; n < CHUNKS; n++) begin
         h_xor = h_xor ^ key[n*`FLOW_EX_IDX_W +: `FLOW_EX_IDX_W];
         h_sum = h_sum + key[n*`FLOW_EX_IDX_W +: `FLOW_EX_IDX_W];
      end
   end

   assign slot0_hit = ex_valid[h_xor] && (ex_match[h_xor] == key);
   assign slot1_hit = ex_valid[h_sum] && (ex_match[h_sum] == key);

   // lowest matching wildcard entry wins
   always_comb begin
      wc_hit = 1'b0;
      wc_idx = '0;
      for (int i = `FLOW_WC_DEPTH - 1; i >= 0; i--) begin
         if (wc_valid[i] && (((key ^ wc_value[i]) & wc_mask[i]) == '0)) begin
            wc_hit = 1'b1;
            wc_idx = flow_table_pkg::wc_idx_t'(i);
         end
      end
   end

   // --------------------
   always_comb begin
      exec_next.valid     = decode_in.valid;
      exec_next.req_id    = decode_in.req_id;
      exec_next.pkt_len   = decode_in.lookup.pkt_len;
      exec_next.ex_hit    = slot0_hit || slot1_hit;
      exec_next.ex_idx    = slot0_hit ? h_xor : h_sum;
      exec_next.wc_hit    = wc_hit;
      exec_next.wc_idx    = wc_idx;
      exec_next.ex_action = slot0_hit ? ex_action[h_xor] : ex_action[h_sum];
      exec_next.wc_action = wc_action[wc_idx];
      exec_next.host_acc  = is_host;
      exec_next.host_op   = decode_in.host.op;
      exec_next.tbl_sel   = decode_in.host.tbl_sel;
      exec_next.host_idx  = hi;
      // a write echoes what goes into the table
      if (decode_in.host.op == flow_pipe_pkg::HOST_WRITE) begin
         exec_next.rd_match  = decode_in.host.match;
         exec_next.rd_mask   = decode_in.host.mask;
         exec_next.rd_action = decode_in.host.action;
      end else if (decode_in.host.tbl_sel) begin
         exec_next.rd_match  = wc_valid[hw] ? wc_value[hw] : '0;
         exec_next.rd_mask   = wc_valid[hw] ? wc_mask[hw] : '0;
         exec_next.rd_action = wc_valid[hw] ? wc_action[hw] : '0;
      end else begin
         // exact entries compare every bit
         exec_next.rd_match  = ex_valid[hi] ? ex_match[hi] : '0;
         exec_next.rd_mask   = ex_valid[hi] ? '1 : '0;
         exec_next.rd_action = ex_valid[hi] ? ex_action[hi] : '0;
      end
   end

   always_ff @(posedge asclk) begin
      if (!aresetn) begin
         exec_out.valid <= 1'b0;
      end else begin
         exec_out <= exec_next;
      end
   end

   // --------------------
   // host writes
   always_ff @(posedge asclk) begin
      if (!aresetn) begin
         ex_valid <= '0;
         wc_valid <= '0;
      end else if (host_wr) begin
         if (decode_in.host.tbl_sel) begin
            wc_valid[hw] <= 1'b1;
         end else begin
            ex_valid[hi] <= 1'b1;
         end
      end
   end

   always_ff @(posedge asclk) begin
      if (host_wr) begin
         if (decode_in.host.tbl_sel) begin
            wc_value[hw]  <= decode_in.host.match;
            wc_mask[hw]   <= decode_in.host.mask;
            wc_action[hw] <= decode_in.host.action;
         end else begin
            ex_match[hi]  <= decode_in.host.match;
            ex_action[hi] <= decode_in.host.action;
         end
      end
   end

endmodule

// ==== hdl/flow_table_pkg.sv ====
// types for flow table contents, per-entry statistics
// and the global lookup counters

`include "flow_consts.svh"

package flow_table_pkg;

   // --------------------
   // table fields
   typedef logic [`FLOW_MATCH_W-1:0]   match_t;
   // zero action means drop
   typedef logic [`FLOW_ACTION_W-1:0]  action_t;
   typedef logic [`FLOW_PKT_LEN_W-1:0] pkt_len_t;
   typedef logic [`FLOW_EX_IDX_W-1:0]  ex_idx_t;
   typedef logic [`FLOW_WC_IDX_W-1:0]  wc_idx_t;
   typedef logic [`FLOW_CNT_W-1:0]     cnt_t;

   // --------------------
   // statistics
   typedef struct packed {
      cnt_t pkt_count;
      cnt_t byte_count;
   } flow_stats_t;

   typedef struct packed {
      cnt_t exact_hit;
      cnt_t exact_miss;
      cnt_t wc_hit;
      cnt_t wc_miss;
   } flow_counters_t;

endpackage

// ==== tb/flow_model.svh ====
// reference model of the flow tables, both key hashes,
// per-entry statistics and the global counters

`ifndef FLOW_MODEL_SVH
`define FLOW_MODEL_SVH

flow_table_pkg::match_t         m_ex_match  [1 << `FLOW_EX_IDX_W];
flow_table_pkg::action_t        m_ex_action [1 << `FLOW_EX_IDX_W];
logic                           m_ex_valid  [1 << `FLOW_EX_IDX_W];
flow_table_pkg::flow_stats_t    m_ex_stats  [1 << `FLOW_EX_IDX_W];
flow_table_pkg::match_t         m_wc_value  [`FLOW_WC_DEPTH];
flow_table_pkg::match_t         m_wc_mask   [`FLOW_WC_DEPTH];
flow_table_pkg::action_t        m_wc_action [`FLOW_WC_DEPTH];
logic                           m_wc_valid  [`FLOW_WC_DEPTH];
flow_table_pkg::flow_stats_t    m_wc_stats  [`FLOW_WC_DEPTH];
flow_table_pkg::flow_counters_t m_counters;
flow_table_pkg::cnt_t           m_drop      [`FLOW_N_PORTS];

function automatic void clear_model();
   for (int i = 0; i < (1 << `FLOW_EX_IDX_W); i++) begin
      m_ex_valid[i] = 1'b0;
      m_ex_stats[i] = '0;
   end
   for (int i = 0; i < `FLOW_WC_DEPTH; i++) begin
      m_wc_valid[i] = 1'b0;
      m_wc_stats[i] = '0;
   end
   m_counters = '0;
   for (int p = 0; p < `FLOW_N_PORTS; p++) begin
      m_drop[p] = '0;
   end
endfunction

// xor of all nibbles
function automatic flow_table_pkg::ex_idx_t key_hash_xor(flow_table_pkg::match_t key);
   flow_table_pkg::ex_idx_t h;
   h = '0;
   for (int n = 0; n < 16; n++) begin
      h = h ^ key[n*4 +: 4];
   end
   return h;
endfunction

// sum of all nibbles mod 16
function automatic flow_table_pkg::ex_idx_t key_hash_sum(flow_table_pkg::match_t key);
   flow_table_pkg::ex_idx_t h;
   h = '0;
   for (int n = 0; n < 16; n++) begin
      h = h + key[n*4 +: 4];
   end
   return h;
endfunction

// one lookup, updates stats and counters, returns the action
function automatic flow_table_pkg::action_t predict_lookup(
   flow_table_pkg::match_t key, flow_table_pkg::pkt_len_t len, int port);
   flow_table_pkg::ex_idx_t h0;
   flow_table_pkg::ex_idx_t h1;
   int                      ex_i;
   int                      wc_i;
   h0   = key_hash_xor(key);
   h1   = key_hash_sum(key);
   ex_i = -1;
   wc_i = -1;
   if (m_ex_valid[h0] && m_ex_match[h0] == key) begin
      ex_i = int'(h0);
   end else if (m_ex_valid[h1] && m_ex_match[h1] == key) begin
      ex_i = int'(h1);
   end
   for (int i = 0; i < `FLOW_WC_DEPTH; i++) begin
      if (wc_i < 0 && m_wc_valid[i] && ((key ^ m_wc_value[i]) & m_wc_mask[i]) == '0) begin
         wc_i = i;
      end
   end
   if (ex_i >= 0) m_counters.exact_hit++;
   else m_counters.exact_miss++;
   if (wc_i >= 0) m_counters.wc_hit++;
   else m_counters.wc_miss++;
   if (ex_i >= 0) begin
      m_ex_stats[ex_i].pkt_count++;
      m_ex_stats[ex_i].byte_count += flow_table_pkg::cnt_t'(len);
      return m_ex_action[ex_i];
   end else if (wc_i >= 0) begin
      m_wc_stats[wc_i].pkt_count++;
      m_wc_stats[wc_i].byte_count += flow_table_pkg::cnt_t'(len);
      return m_wc_action[wc_i];
   end
   m_drop[port]++;
   return '0;
endfunction

`endif

// ==== tb/tb_flow_table_ctrl.sv ====
// flow-table controller testbench with random host loads, lookups,
// fairness under load and statistics, checked against a model

`timescale 1ns/1ps
`include "flow_consts.svh"

module tb_flow_table_ctrl;

   localparam int N         = `FLOW_N_PORTS;
   localparam int LAT       = `FLOW_LATENCY;
   localparam int EX_DEPTH  = 1 << `FLOW_EX_IDX_W;
   localparam int WC_DEPTH  = `FLOW_WC_DEPTH;
   localparam int N_LOOKUPS = 60;
   localparam int N_FAIR    = 30;
   localparam int N_BURST   = 200;
   localparam int TOTAL_REQ = 3 * (EX_DEPTH + WC_DEPTH) + 2 * N_LOOKUPS
                              + (N + 1) * N_FAIR + N_BURST;
   localparam int WATCHDOG_CYCLES = TOTAL_REQ * (N + 1 + LAT) + 1000;
   // widest value compared is a whole host response
   localparam int CHECK_W   = $bits(flow_pipe_pkg::host_rsp_t);

   logic                           asclk;
   logic                           aresetn;
   logic [N-1:0]                   lookup_valid;
   flow_pipe_pkg::lookup_req_t     lookup_req [N];
   logic [N-1:0]                   lookup_ack;
   logic [N-1:0]                   lookup_done;
   flow_table_pkg::action_t        action_out;
   logic                           host_valid;
   flow_pipe_pkg::host_req_t       host_req;
   logic                           host_ack;
   logic                           host_done;
   flow_pipe_pkg::host_rsp_t       host_rsp;
   flow_table_pkg::flow_counters_t counters;
   flow_table_pkg::cnt_t           drop_count [N];

   // requester queues and expected results
   flow_pipe_pkg::lookup_req_t port_q [N][$];
   flow_table_pkg::action_t    exp_act_q [N][$];
   int                         exp_due_q [N][$];
   flow_pipe_pkg::host_req_t   host_q [$];
   flow_pipe_pkg::host_rsp_t   exp_rsp_q [$];
   int                         host_due_q [$];
   logic [N:0]                 busy;
   logic [N:0]                 release_nxt;
   int                         wait_cnt [N+1];
   int                         cycle;

   `include "flow_model.svh"

   flow_table_ctrl u_flow_table_ctrl (.*);

   always #10 asclk = ~asclk;

   task automatic check_value(input string name, input logic [CHECK_W-1:0] exp,
                              input logic [CHECK_W-1:0] act);
      if (exp !== act) begin
         $display("Error: %s expected %h actual %h", name, exp, act);
         $display("RESULT: FAIL");
         $fatal(1);
      end
   endtask

   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("RESULT: FAIL");
      $fatal(1);
   endtask

   // --------------------
   // host side of the model
   function automatic flow_pipe_pkg::host_rsp_t apply_host(flow_pipe_pkg::host_req_t r);
      flow_pipe_pkg::host_rsp_t rsp;
      int                       w;
      w   = int'(r.index) % WC_DEPTH;
      rsp = '0;
      if (r.op == flow_pipe_pkg::HOST_WRITE) begin
         if (r.tbl_sel) begin
            m_wc_value[w]  = r.match;
            m_wc_mask[w]   = r.mask;
            m_wc_action[w] = r.action;
            m_wc_valid[w]  = 1'b1;
            m_wc_stats[w]  = '0;
         end else begin
            m_ex_match[r.index]  = r.match;
            m_ex_action[r.index] = r.action;
            m_ex_valid[r.index]  = 1'b1;
            m_ex_stats[r.index]  = '0;
         end
         rsp.match  = r.match;
         rsp.mask   = r.mask;
         rsp.action = r.action;
      end else if (r.tbl_sel && m_wc_valid[w]) begin
         rsp = {m_wc_value[w], m_wc_mask[w], m_wc_action[w], m_wc_stats[w]};
      end else if (!r.tbl_sel && m_ex_valid[r.index]) begin
         rsp = {m_ex_match[r.index], {64{1'b1}}, m_ex_action[r.index], m_ex_stats[r.index]};
      end
      return rsp;
   endfunction

   function automatic flow_table_pkg::match_t rand_key();
      return {$urandom, $urandom};
   endfunction

   // the key is bent so one of its hashes lands on idx
   function automatic flow_pipe_pkg::host_req_t exact_write(int idx);
      flow_pipe_pkg::host_req_t r;
      flow_table_pkg::ex_idx_t  d;
      r.op      = flow_pipe_pkg::HOST_WRITE;
      r.tbl_sel = 1'b0;
      r.index   = flow_table_pkg::ex_idx_t'(idx);
      r.match   = rand_key();
      if (idx % 2 == 0) begin
         d = key_hash_xor(r.match) ^ r.index;
         r.match[3:0] = r.match[3:0] ^ d;
      end else begin
         d = r.index - key_hash_sum(r.match);
         r.match[3:0] = r.match[3:0] + d;
      end
      r.mask   = '1;
      r.action = $urandom | 32'h1;
      return r;
   endfunction

   // sparse masks so random keys hit now and then
   function automatic flow_pipe_pkg::host_req_t wc_write(int idx);
      flow_pipe_pkg::host_req_t r;
      int                       nbits;
      r.op      = flow_pipe_pkg::HOST_WRITE;
      r.tbl_sel = 1'b1;
      r.index   = flow_table_pkg::ex_idx_t'(idx);
      r.match   = rand_key();
      r.mask    = '0;
      nbits     = 1 + $urandom % 3;
      repeat (nbits) r.mask[$urandom % 64] = 1'b1;
      r.action  = $urandom | 32'h1;
      return r;
   endfunction

   function automatic flow_pipe_pkg::host_req_t read_req(logic tbl, int idx);
      flow_pipe_pkg::host_req_t r;
      r         = '0;
      r.op      = flow_pipe_pkg::HOST_READ;
      r.tbl_sel = tbl;
      r.index   = flow_table_pkg::ex_idx_t'(idx);
      return r;
   endfunction

   // kind 0 stored exact key, 1 near a wildcard entry, 2 random
   function automatic flow_table_pkg::match_t pick_key(int kind);
      int w;
      w = $urandom % WC_DEPTH;
      if (kind == 0) return m_ex_match[$urandom % EX_DEPTH];
      if (kind == 1) return (rand_key() & ~m_wc_mask[w]) | (m_wc_value[w] & m_wc_mask[w]);
      return rand_key();
   endfunction

   task automatic push_lookup(int p, flow_table_pkg::match_t key);
      flow_pipe_pkg::lookup_req_t r;
      r.match   = key;
      r.pkt_len = flow_table_pkg::pkt_len_t'($urandom);
      port_q[p].push_back(r);
   endtask

   task automatic push_all_reads();
      for (int i = 0; i < EX_DEPTH; i++) host_q.push_back(read_req(1'b0, i));
      for (int i = 0; i < WC_DEPTH; i++) host_q.push_back(read_req(1'b1, i));
   endtask

   // --------------------
   task automatic check_dones(input string name);
      for (int p = 0; p < N; p++) begin
         if (lookup_done[p]) begin
            if (exp_act_q[p].size() == 0) fail_run("lookup done without a granted request");
            check_value({name, " latency"}, exp_due_q[p].pop_front(), cycle);
            check_value({name, " action"}, exp_act_q[p].pop_front(), action_out);
         end else if (exp_due_q[p].size() > 0 && exp_due_q[p][0] <= cycle) begin
            fail_run($sformatf("lookup done missing on port %0d in %s", p, name));
         end
      end
      if (host_done) begin
         if (exp_rsp_q.size() == 0) fail_run("host done without a granted request");
         check_value({name, " host latency"}, host_due_q.pop_front(), cycle);
         check_value({name, " host response"}, exp_rsp_q.pop_front(), host_rsp);
      end else if (host_due_q.size() > 0 && host_due_q[0] <= cycle) begin
         fail_run($sformatf("host done missing in %s", name));
      end
   endtask

   // runs every queued request through the DUT and checks it
   task automatic run_traffic(input string name);
      logic [N:0] acks;
      logic       work;
      work = 1'b1;
      while (work) begin
         @(posedge asclk);
         #2;
         cycle++;
         acks = {host_ack, lookup_ack};
         if ($countones(acks) > 1) fail_run("more than one ack high in one cycle");
         check_dones(name);
         work = 1'b0;
         for (int p = 0; p <= N; p++) begin
            if (release_nxt[p]) begin
               release_nxt[p] = 1'b0;
               busy[p]        = 1'b0;
            end
            if (acks[p]) begin
               if (!busy[p]) fail_run($sformatf("ack on idle requester %0d", p));
               release_nxt[p] = 1'b1;
               if (p < N) begin
                  exp_act_q[p].push_back(predict_lookup(lookup_req[p].match,
                                                        lookup_req[p].pkt_len, p));
                  exp_due_q[p].push_back(cycle + LAT);
               end else begin
                  exp_rsp_q.push_back(apply_host(host_req));
                  host_due_q.push_back(cycle + LAT);
               end
            end else if (busy[p]) begin
               wait_cnt[p]++;
               if (wait_cnt[p] > N) fail_run($sformatf("requester %0d starved", p));
            end
            // load the next request once the last one is released
            if (!busy[p] && p < N && port_q[p].size() > 0) begin
               lookup_req[p] = port_q[p].pop_front();
               busy[p]       = 1'b1;
               wait_cnt[p]   = 0;
            end else if (!busy[p] && p == N && host_q.size() > 0) begin
               host_req    = host_q.pop_front();
               busy[p]     = 1'b1;
               wait_cnt[p] = 0;
            end
            if (busy[p] || (p < N && exp_due_q[p].size() > 0)) work = 1'b1;
         end
         if (host_due_q.size() > 0) work = 1'b1;
         lookup_valid = busy[N-1:0];
         host_valid   = busy[N];
      end
   endtask

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge asclk);
      $display("watchdog expired, the DUT stopped answering requests");
      $display("RESULT: FAIL");
      $fatal(1);
   end

   // --------------------
   initial begin
      asclk        = 1'b0;
      aresetn      = 1'b0;
      lookup_valid = '0;
      host_valid   = 1'b0;
      host_req     = '0;
      for (int p = 0; p < N; p++) lookup_req[p] = '0;
      busy         = '0;
      release_nxt  = '0;
      cycle        = 0;
      void'($urandom(24));
      clear_model();
      repeat (10) @(posedge asclk);
      #2 aresetn = 1'b1;

      for (int i = 0; i < EX_DEPTH; i++) host_q.push_back(exact_write(i));
      for (int i = 0; i < WC_DEPTH; i++) host_q.push_back(wc_write(i));
      run_traffic("host_load");
      push_all_reads();
      run_traffic("host_readback");

      repeat (N_LOOKUPS) push_lookup($urandom % N, pick_key(0));
      run_traffic("exact_lookup");

      repeat (N_LOOKUPS) push_lookup($urandom % N, pick_key(1 + $urandom % 2));
      run_traffic("wildcard_miss");

      // every requester keeps a request up the whole time
      for (int p = 0; p < N; p++) begin
         repeat (N_FAIR) push_lookup(p, pick_key($urandom % 3));
      end
      for (int i = 0; i < N_FAIR; i++) host_q.push_back(read_req(i % 2, $urandom % WC_DEPTH));
      run_traffic("fairness");

      repeat (N_BURST) push_lookup($urandom % N, pick_key($urandom % 3));
      run_traffic("stats_burst");
      push_all_reads();
      run_traffic("stats_readback");
      check_value("counters", m_counters, counters);
      for (int p = 0; p < N; p++) begin
         check_value($sformatf("drop_count[%0d]", p), m_drop[p], drop_count[p]);
      end

      $display("RESULT: PASS");
      $finish;
   end

endmodule
